/* design/fetchPkg.sv */
// ==================================================
// shared definitions for the fetch stage
//   instruction and length code widths
//   opcode enum and its decode function
//   byte length codes
// ==================================================

package fetchPkg;

	// full width of an expanded instruction
	localparam int INSN_W = 48;
	// width of a byte length code
	localparam int LEN_W = 3;
	// opcode field sits in bits 5..0
	localparam int OP_W = 6;

	// ==================================================
	// byte length codes
	// ==================================================
	// compressed word
	localparam logic [LEN_W-1:0] LEN_2 = 3'd2;
	// normal word
	localparam logic [LEN_W-1:0] LEN_4 = 3'd4;
	// long word
	localparam logic [LEN_W-1:0] LEN_6 = 3'd6;

	// opcodes the front end cares about
	typedef enum logic [OP_W-1:0] {
		OP_ALU  = 6'h04,
		OP_JMP  = 6'h18,
		OP_CALL = 6'h19,
		OP_RET  = 6'h29,
		OP_BCC  = 6'h38
	} opcodeE;

	// map a raw opcode field onto the enum
	// anything unknown behaves like an ordinary instruction
	function automatic opcodeE decodeOp(input logic [OP_W-1:0] code);
		opcodeE op;
		case (code)
			OP_BCC, OP_JMP, OP_CALL, OP_RET:
				op = opcodeE'(code);
			default:
				op = OP_ALU;
		endcase
		return op;
	endfunction

endpackage

/* design/insnExpander.sv */
// ==================================================
// length decode and expansion of fetched words
//   2-byte compressed words grow to the 48-bit form
//   4-byte words get their unused bytes cleared
// ==================================================

`timescale 1ns/1ps

module insnExpander
(
	input  logic [fetchPkg::INSN_W-1:0] rawInsn_i,
	output logic [fetchPkg::INSN_W-1:0] insn_o,
	output logic [fetchPkg::LEN_W-1:0]  len_o
);

	// bit 7 marks a compressed word
	logic isCompressed;
	// bit 6 selects the long form for uncompressed words
	logic isLong;
	// opcode field, identical in all forms
	logic [fetchPkg::OP_W-1:0] opBits;
	// candidate expanded words
	logic [fetchPkg::INSN_W-1:0] expandC;
	logic [fetchPkg::INSN_W-1:0] expand4;

	assign isCompressed = rawInsn_i[7];
	assign isLong = rawInsn_i[6];
	assign opBits = rawInsn_i[fetchPkg::OP_W-1:0];

	// compressed form
	// byte 1 becomes the low displacement byte at 23..16
	// length bits 7..6 are cleared, rest is zero
	assign expandC = {
		{(fetchPkg::INSN_W-24){1'b0}},
		rawInsn_i[15:8],
		8'h00,
		2'b00,
		opBits
	};

	// only the low four bytes of a 4-byte word are valid
	assign expand4 = {{(fetchPkg::INSN_W-32){1'b0}}, rawInsn_i[31:0]};

	// ==================================================
	// length rule and word select
	// ==================================================
	always_comb
	begin
		if (isCompressed)
		begin
			len_o = fetchPkg::LEN_2;
			insn_o = expandC;
		end
		else if (!isLong)
		begin
			len_o = fetchPkg::LEN_4;
			insn_o = expand4;
		end
		else
		begin
			// 6-byte word uses every raw bit
			len_o = fetchPkg::LEN_6;
			insn_o = rawInsn_i;
		end
	end

endmodule

/* design/branchTarget.sv */
// ==================================================
// head instruction classifier
//   opcode decode of the head slot
//   branch, jump, call and return targets
//   take decision and call/return flags
// ==================================================

`timescale 1ns/1ps

module branchTarget
#(
	parameter int AW = 32
)
(
	input  logic [fetchPkg::INSN_W-1:0] insn_i,
	input  logic [AW-1:0]               pc_i,
	input  logic                        valid_i,
	input  logic                        predictTaken_i,
	input  logic [AW-1:0]               retPc_i,
	output logic [AW-1:0]               target_o,
	output logic                        take_o,
	output logic                        isCall_o,
	output logic                        isRet_o
);

	// decoded opcode of the head
	fetchPkg::opcodeE op;
	// pc relative target of a conditional branch
	logic [AW-1:0] relTarget;
	// absolute target of jump and call
	logic [31:0] absTarget;
	// unconditional redirect
	logic isUncond;

	assign op = fetchPkg::decodeOp(insn_i[fetchPkg::OP_W-1:0]);

	// displacement in 31..16, sign extended to the address width
	assign relTarget = pc_i + {{(AW-16){insn_i[31]}}, insn_i[31:16]};

	// address field in 39..8, always halfword aligned
	assign absTarget = {insn_i[39:9], 1'b0};

	// ==================================================
	// target select
	// ==================================================
	always_comb
	begin
		case (op)
			fetchPkg::OP_BCC:
				target_o = relTarget;
			fetchPkg::OP_JMP, fetchPkg::OP_CALL:
				target_o = AW'(absTarget);
			fetchPkg::OP_RET:
				target_o = retPc_i;
			default:
				// never taken, target is a don't care
				target_o = pc_i;
		endcase
	end

	assign isCall_o = (op == fetchPkg::OP_CALL);
	assign isRet_o = (op == fetchPkg::OP_RET);
	assign isUncond = (op == fetchPkg::OP_JMP) || isCall_o || isRet_o;

	// ==================================================
	// take decision
	// ==================================================
	// jumps, calls and returns always redirect
	// conditional branches follow the prediction
	always_comb
	begin
		take_o = 1'b0;
		if (valid_i)
		begin
			if (isUncond)
				take_o = 1'b1;
			else if (op == fetchPkg::OP_BCC)
				take_o = predictTaken_i;
		end
	end

endmodule

/* design/returnStack.sv */
// ==================================================
// return address stack
//   circular storage with top pointer and count
//   push on a queued call, pop on a queued return
//   empty stack reads as the reset address
// ==================================================

`timescale 1ns/1ps

module returnStack
#(
	parameter int            AW        = 32,
	parameter logic [AW-1:0] RST_PC    = 32'h0000_0100,
	parameter int            RSB_DEPTH = 8
)
(
	input  logic          clk,
	input  logic          rst,
	input  logic          push_i,
	input  logic [AW-1:0] pushPc_i,
	input  logic          pop_i,
	output logic [AW-1:0] top_o
);

	localparam int PTR_W = $clog2(RSB_DEPTH);
	// count saturates here, older entries get overwritten
	localparam logic [PTR_W:0] FULL_CNT = (PTR_W+1)'(RSB_DEPTH);

	// return addresses
	logic [AW-1:0] stack [RSB_DEPTH];
	// index of the current top entry
	logic [PTR_W-1:0] topPtr;
	// slot the next push lands in, wraps around
	logic [PTR_W-1:0] nextPtr;
	// number of live entries
	logic [PTR_W:0] count;

	assign nextPtr = topPtr + 1'b1;

	// ==================================================
	// pointer and occupancy
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			topPtr <= '0;
			count <= '0;
		end
		else if (push_i)
		begin
			topPtr <= nextPtr;
			if (count != FULL_CNT)
				count <= count + 1'b1;
		end
		else if (pop_i && count != '0)
		begin
			// popping an empty stack leaves it empty
			topPtr <= topPtr - 1'b1;
			count <= count - 1'b1;
		end
	end

	// entry write
	always_ff @(posedge clk)
	begin
		if (push_i)
			stack[nextPtr] <= pushPc_i;
	end

	assign top_o = (count == '0) ? RST_PC : stack[topPtr];

	// only one instruction is queued per cycle, so a call and a return
	// never retire together
	aPushPop: assert property (@(posedge clk) disable iff (rst) !(push_i && pop_i));

endmodule

/* design/fetchBuffer.sv */
// ==================================================
// two-slot fetch buffer
//   slots A and B with valid, word, pc and length
//   head pointer and fetch address register
//   fill steering, taken-head redirect, miss flush
//   return stack push and pop strobes
// ==================================================

`timescale 1ns/1ps

module fetchBuffer
#(
	parameter int            AW     = 32,
	parameter logic [AW-1:0] RST_PC = 32'h0000_0100
)
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic [fetchPkg::INSN_W-1:0] fetchInsn_i,
	input  logic [fetchPkg::LEN_W-1:0]  fetchLen_i,
	input  logic                        hit_i,
	input  logic                        freeze_i,
	input  logic                        queued_i,
	input  logic                        branchMiss_i,
	input  logic [AW-1:0]               missPc_i,
	input  logic [AW-1:0]               target_i,
	input  logic                        take_i,
	input  logic                        isCall_i,
	input  logic                        isRet_i,
	output logic [AW-1:0]               pc_o,
	output logic                        headValid_o,
	output logic [fetchPkg::INSN_W-1:0] headInsn_o,
	output logic [AW-1:0]               headPc_o,
	output logic [fetchPkg::LEN_W-1:0]  headLen_o,
	output logic                        push_o,
	output logic [AW-1:0]               pushPc_o,
	output logic                        pop_o
);

	// slot state
	logic aValid;
	logic bValid;
	logic [fetchPkg::INSN_W-1:0] aInsn;
	logic [fetchPkg::INSN_W-1:0] bInsn;
	logic [AW-1:0] aPc;
	logic [AW-1:0] bPc;
	logic [fetchPkg::LEN_W-1:0] aLen;
	logic [fetchPkg::LEN_W-1:0] bLen;
	// head pointer, low selects A
	logic headSel;
	// fetch address
	logic [AW-1:0] fetchPc;
	// valid bit of the slot behind the head
	logic otherValid;
	// head accepted by the queue stage
	logic headQueued;
	// slot write enables
	logic fillEn;
	logic fillA;
	logic fillB;

	// ==================================================
	// head select
	// ==================================================
	assign headValid_o = headSel ? bValid : aValid;
	assign headInsn_o = headSel ? bInsn : aInsn;
	assign headPc_o = headSel ? bPc : aPc;
	assign headLen_o = headSel ? bLen : aLen;
	assign otherValid = headSel ? aValid : bValid;
	assign pc_o = fetchPc;

	assign headQueued = queued_i & headValid_o;

	// return stack strobes, return address is the next sequential pc
	assign push_o = headQueued & isCall_i;
	assign pop_o = headQueued & isRet_i;
	assign pushPc_o = headPc_o + {{(AW-fetchPkg::LEN_W){1'b0}}, headLen_o};

	// fill only in the plain sequential case
	// a miss or a taken head suppresses it
	assign fillEn = hit_i & ~freeze_i & ~branchMiss_i & ~take_i & ~(aValid & bValid);
	// A is preferred, which also covers the both-empty case
	assign fillA = fillEn & ~aValid;
	assign fillB = fillEn & aValid & ~bValid;

	// ==================================================
	// control state
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			aValid <= 1'b0;
			bValid <= 1'b0;
			headSel <= 1'b0;
			fetchPc <= RST_PC;
		end
		else if (branchMiss_i)
		begin
			// flush everything and restart at the miss address
			aValid <= 1'b0;
			bValid <= 1'b0;
			headSel <= 1'b0;
			fetchPc <= missPc_i;
		end
		else if (take_i)
		begin
			// head redirects fetch, partner slot was fetched down the wrong path
			fetchPc <= target_i;
			if (headSel)
			begin
				bValid <= ~headQueued;
				aValid <= 1'b0;
			end
			else
			begin
				aValid <= ~headQueued;
				bValid <= 1'b0;
			end
			headSel <= headSel ^ headQueued;
		end
		else
		begin
			// retire the head and move to the partner
			if (headQueued)
			begin
				if (headSel)
					bValid <= 1'b0;
				else
					aValid <= 1'b0;
				headSel <= ~headSel;
			end
			if (fillA)
			begin
				aValid <= 1'b1;
				// empty buffer restarts at A
				if (!bValid)
					headSel <= 1'b0;
			end
			if (fillB)
				bValid <= 1'b1;
			if (fillEn)
				fetchPc <= fetchPc + {{(AW-fetchPkg::LEN_W){1'b0}}, fetchLen_i};
		end
	end

	// ==================================================
	// slot payload
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (fillA)
		begin
			aInsn <= fetchInsn_i;
			aPc <= fetchPc;
			aLen <= fetchLen_i;
		end
		if (fillB)
		begin
			bInsn <= fetchInsn_i;
			bPc <= fetchPc;
			bLen <= fetchLen_i;
		end
	end

	// queue stage may only accept a valid head
	aQueuedValid: assert property (@(posedge clk) disable iff (rst) queued_i |-> headValid_o);

	// the pointer never rests on an empty slot while the partner holds a word
	aHeadConsistent: assert property (@(posedge clk) disable iff (rst)
		!(!headValid_o && otherValid));

endmodule

/* design/fetchUnit.sv */
// ==================================================
// instruction fetch stage top level
//   length decode and expander
//   two-slot fetch buffer
//   branch target and take logic
//   return address stack
// ==================================================

`timescale 1ns/1ps

module fetchUnit
#(
	parameter int            AW        = 32,
	parameter logic [AW-1:0] RST_PC    = 32'h0000_0100,
	parameter int            RSB_DEPTH = 8
)
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic [fetchPkg::INSN_W-1:0] insn_i,
	input  logic                        hit_i,
	input  logic                        freeze_i,
	input  logic                        predictTaken_i,
	input  logic                        queued_i,
	input  logic                        branchMiss_i,
	input  logic [AW-1:0]               missPc_i,
	output logic [AW-1:0]               pc_o,
	output logic                        headValid_o,
	output logic [fetchPkg::INSN_W-1:0] headInsn_o,
	output logic [AW-1:0]               headPc_o,
	output logic [fetchPkg::LEN_W-1:0]  headLen_o,
	output logic                        takeBranch_o
);

	// expanded fetch word and its length
	logic [fetchPkg::INSN_W-1:0] expInsn;
	logic [fetchPkg::LEN_W-1:0] expLen;
	// head classification
	logic [AW-1:0] target;
	logic isCall;
	logic isRet;
	// return stack traffic
	logic push;
	logic pop;
	logic [AW-1:0] pushPc;
	logic [AW-1:0] retPc;

	insnExpander i_expander
	(
		.rawInsn_i (insn_i),
		.insn_o    (expInsn),
		.len_o     (expLen)
	);

	fetchBuffer #(.AW(AW), .RST_PC(RST_PC)) i_buffer
	(
		.clk          (clk),
		.rst          (rst),
		.fetchInsn_i  (expInsn),
		.fetchLen_i   (expLen),
		.hit_i        (hit_i),
		.freeze_i     (freeze_i),
		.queued_i     (queued_i),
		.branchMiss_i (branchMiss_i),
		.missPc_i     (missPc_i),
		.target_i     (target),
		.take_i       (takeBranch_o),
		.isCall_i     (isCall),
		.isRet_i      (isRet),
		.pc_o         (pc_o),
		.headValid_o  (headValid_o),
		.headInsn_o   (headInsn_o),
		.headPc_o     (headPc_o),
		.headLen_o    (headLen_o),
		.push_o       (push),
		.pushPc_o     (pushPc),
		.pop_o        (pop)
	);

	branchTarget #(.AW(AW)) i_target
	(
		.insn_i         (headInsn_o),
		.pc_i           (headPc_o),
		.valid_i        (headValid_o),
		.predictTaken_i (predictTaken_i),
		.retPc_i        (retPc),
		.target_o       (target),
		.take_o         (takeBranch_o),
		.isCall_o       (isCall),
		.isRet_o        (isRet)
	);

	returnStack #(.AW(AW), .RST_PC(RST_PC), .RSB_DEPTH(RSB_DEPTH)) i_rsb
	(
		.clk      (clk),
		.rst      (rst),
		.push_i   (push),
		.pushPc_i (pushPc),
		.pop_i    (pop),
		.top_o    (retPc)
	);

endmodule

/* tb/fetchUnitTb.sv */
// ==================================================
// testbench for the fetch stage
//   clock, reset and hashed instruction memory
//   queue stage model, misses, freeze and hit drops
//   reference model with return stack, checker
//   watchdog
// ==================================================

`timescale 1ns/1ps

module fetchUnitTb;

	localparam logic [31:0] RST_PC = 32'h0000_0100;
	localparam int TOTAL_ACCEPT = 300;
	// 20 cycles of 40 ns per planned acceptance, plus reset
	localparam int WATCHDOG_NS = TOTAL_ACCEPT * 20 * 40 + 1000;

	logic clk;
	logic rst;
	logic [47:0] insn_i;
	logic hit_i;
	logic freeze_i;
	logic predictTaken_i;
	logic queued_i;
	logic branchMiss_i;
	logic [31:0] missPc_i;
	logic [31:0] pc_o;
	logic headValid_o;
	logic [47:0] headInsn_o;
	logic [31:0] headPc_o;
	logic [2:0] headLen_o;
	logic takeBranch_o;

	// stimulus controls
	int mode;
	int reqMode;
	int qRate;
	bit missOn;
	bit freezeOn;
	bit running;
	bit phaseReq;
	// checker state
	logic [31:0] expPc;
	logic [31:0] rsbModel[$];
	bit predSeen;
	int accepted;
	int errors;

	fetchUnit i_dut
	(
		.clk            (clk),
		.rst            (rst),
		.insn_i         (insn_i),
		.hit_i          (hit_i),
		.freeze_i       (freeze_i),
		.predictTaken_i (predictTaken_i),
		.queued_i       (queued_i),
		.branchMiss_i   (branchMiss_i),
		.missPc_i       (missPc_i),
		.pc_o           (pc_o),
		.headValid_o    (headValid_o),
		.headInsn_o     (headInsn_o),
		.headPc_o       (headPc_o),
		.headLen_o      (headLen_o),
		.takeBranch_o   (takeBranch_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// integer hash over the whole address
	function automatic logic [31:0] mixAddr(input logic [31:0] a);
		logic [31:0] h;
		h = a ^ (a >> 15);
		h = h * 32'h2c1b_3c6d;
		h = h ^ (h >> 12);
		h = h * 32'h297a_2d39;
		return h ^ (h >> 15);
	endfunction

	// ==================================================
	// program memory, raw word at any address
	// ==================================================
	function automatic logic [47:0] progWord(input logic [31:0] pc, input int m);
		logic [31:0] h1;
		logic [31:0] h2;
		logic [47:0] w;
		logic [5:0] op;
		logic [2:0] sel;
		h1 = mixAddr(pc);
		h2 = mixAddr(pc ^ 32'h5bd1_e995);
		sel = h2[18:16];
		// plain opcode or an unknown code, both ordinary
		op = h2[20] ? 6'h04 : 6'h07;
		if (m == 1 && sel == 0)
			op = fetchPkg::OP_JMP;
		else if (m == 1 && sel < 3)
			op = fetchPkg::OP_BCC;
		else if (m == 2 && sel == 0)
			op = fetchPkg::OP_CALL;
		else if (m == 2 && sel == 1)
			op = fetchPkg::OP_RET;
		else if (m == 4 && sel == 0)
			op = fetchPkg::OP_JMP;
		else if (m == 4 && sel == 1)
			op = fetchPkg::OP_BCC;
		else if (m == 4 && sel == 2)
			op = fetchPkg::OP_CALL;
		else if (m == 4 && sel == 3)
			op = fetchPkg::OP_RET;
		w = {h2[15:0], h1};
		// form select, half of all words compressed
		if (h2[22:21] == 2'd0)
			w[7:6] = 2'b00;
		else if (h2[22:21] == 2'd1)
			w[7:6] = 2'b01;
		else
			w[7] = 1'b1;
		w[5:0] = op;
		return w;
	endfunction

	assign insn_i = progWord(pc_o, mode);

	function automatic logic [2:0] lenRef(input logic [47:0] raw);
		if (raw[7])
			return 3'd2;
		return raw[6] ? 3'd6 : 3'd4;
	endfunction

	// full form, only the valid low bytes survive
	function automatic logic [47:0] expandRef(input logic [47:0] raw, input logic [2:0] len);
		if (len == 3'd2)
			return {24'h0, raw[15:8], 10'h0, raw[5:0]};
		if (len == 3'd4)
			return {16'h0, raw[31:0]};
		return raw;
	endfunction

	// jumps, calls and returns always redirect, branches only when predicted
	function automatic logic takesRef(input logic [47:0] insn, input logic pred);
		case (insn[5:0])
			6'h18, 6'h19, 6'h29:
				return 1'b1;
			6'h38:
				return pred;
			default:
				return 1'b0;
		endcase
	endfunction

	// next accepted pc, keeps the model return stack up to date
	function automatic logic [31:0] expectNext(input logic [47:0] insn, input logic [31:0] pc,
		input bit pred, input logic [2:0] len);
		logic [31:0] seqPc;
		logic [31:0] ret;
		seqPc = pc + {29'h0, len};
		case (insn[5:0])
			6'h38:
				return pred ? pc + {{16{insn[31]}}, insn[31:16]} : seqPc;
			6'h18:
				return {insn[39:9], 1'b0};
			6'h19:
			begin
				rsbModel.push_back(seqPc);
				// eight entries, oldest one is lost
				if (rsbModel.size() > 8)
					void'(rsbModel.pop_front());
				return {insn[39:9], 1'b0};
			end
			6'h29:
			begin
				ret = RST_PC;
				if (rsbModel.size() > 0)
					ret = rsbModel.pop_back();
				return ret;
			end
			default:
				return seqPc;
		endcase
	endfunction

	// ==================================================
	// stimulus driver
	// ==================================================
	always @(posedge clk)
	begin
		if (!rst && running)
		begin
			hit_i <= ($urandom % 4) != 0;
			predictTaken_i <= ($urandom % 2) == 1;
			freeze_i <= freezeOn && (($urandom % 8) == 0);
			if (phaseReq || (missOn && ($urandom % 30) == 0))
			begin
				branchMiss_i <= 1'b1;
				missPc_i <= phaseReq ? RST_PC : $urandom;
				queued_i <= 1'b0;
				if (phaseReq)
					mode <= reqMode;
				phaseReq = 1'b0;
			end
			else
			begin
				branchMiss_i <= 1'b0;
				// head surely stays valid when nothing retires or flushes now
				queued_i <= headValid_o && !queued_i && !branchMiss_i &&
					(($urandom % 100) < qRate);
			end
		end
	end

	// ==================================================
	// comparison at every accepted head
	// ==================================================
	always @(posedge clk)
	begin
		logic [47:0] raw;
		logic [47:0] expInsn;
		logic [2:0] expLen;
		logic expTake;
		if (rst)
		begin
			expPc = RST_PC;
			predSeen = 1'b0;
		end
		else if (branchMiss_i)
		begin
			expPc = missPc_i;
			predSeen = 1'b0;
		end
		else
		begin
			// a valid head is always the word at the expected pc
			raw = progWord(expPc, mode);
			expLen = lenRef(raw);
			expInsn = expandRef(raw, expLen);
			expTake = headValid_o && takesRef(expInsn, predictTaken_i);
			if (takeBranch_o !== expTake)
			begin
				$display("ERROR %0t takeBranch_o exp %b got %b", $time, expTake, takeBranch_o);
				errors++;
			end
			// a prediction seen once has already redirected fetch
			if (headValid_o && predictTaken_i)
				predSeen = 1'b1;
			if (queued_i)
			begin
				if (headPc_o !== expPc)
				begin
					$display("ERROR %0t headPc_o exp %h got %h", $time, expPc, headPc_o);
					errors++;
				end
				if (headLen_o !== expLen)
				begin
					$display("ERROR %0t headLen_o exp %0d got %0d", $time, expLen, headLen_o);
					errors++;
				end
				if (headInsn_o !== expInsn)
				begin
					$display("ERROR %0t headInsn_o exp %h got %h", $time, expInsn, headInsn_o);
					errors++;
				end
				expPc = expectNext(expInsn, expPc, predSeen, expLen);
				predSeen = 1'b0;
				accepted++;
			end
		end
	end

	// restart at the reset address in a new mode, then wait for goal acceptances
	task automatic runPhase(input int m, input int goal, input int q, input bit miss,
		input bit frz, input string name);
		int startAcc;
		int startErr;
		@(negedge clk);
		startErr = errors;
		reqMode = m;
		qRate = q;
		missOn = miss;
		freezeOn = frz;
		phaseReq = 1'b1;
		wait (phaseReq == 1'b0);
		@(negedge clk);
		startAcc = accepted;
		wait (accepted >= startAcc + goal);
		$display("test %s: %0d accepted, %0d errors", name, goal, errors - startErr);
	endtask

	initial
	begin
		void'($urandom(32'hc454_085e));
		rst = 1'b1;
		hit_i = 1'b0;
		freeze_i = 1'b0;
		predictTaken_i = 1'b0;
		queued_i = 1'b0;
		branchMiss_i = 1'b0;
		missPc_i = '0;
		mode = 0;
		reqMode = 0;
		qRate = 50;
		missOn = 1'b0;
		freezeOn = 1'b0;
		running = 1'b0;
		phaseReq = 1'b0;
		accepted = 0;
		errors = 0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		#1;
		if (headValid_o !== 1'b0)
		begin
			$display("ERROR %0t headValid_o exp 0 got %b", $time, headValid_o);
			errors++;
		end
		if (takeBranch_o !== 1'b0)
		begin
			$display("ERROR %0t takeBranch_o exp 0 got %b", $time, takeBranch_o);
			errors++;
		end
		if (pc_o !== RST_PC)
		begin
			$display("ERROR %0t pc_o exp %h got %h", $time, RST_PC, pc_o);
			errors++;
		end
		$display("test reset state: %0d errors", errors);
		@(negedge clk);
		running = 1'b1;
		runPhase(0, 40, 50, 1'b0, 1'b0, "straight line");
		runPhase(1, 60, 50, 1'b0, 1'b0, "jump and branch");
		runPhase(2, 60, 50, 1'b0, 1'b0, "call and return");
		runPhase(3, 60, 50, 1'b1, 1'b0, "branch miss");
		runPhase(4, 80, 20, 1'b1, 1'b1, "back-pressure and freeze");
		$display("summary: %0d accepted, %0d errors", accepted, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// watchdog
	initial
	begin
		#WATCHDOG_NS;
		$display("watchdog expired: the planned acceptances did not complete in time");
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* tb.f */
design/fetchPkg.sv
design/insnExpander.sv
design/branchTarget.sv
design/returnStack.sv
design/fetchBuffer.sv
design/fetchUnit.sv
tb/fetchUnitTb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := fetchUnitTb
FILELIST   := tb.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf $(OBJ_DIR)
